//--- verilog/bpm_pkg.sv
`default_nettype none

package bpm_pkg;

	////////////////////////////////////////
	// Host bus and register map
	////////////////////////////////////////
	localparam int bus_addr_w = 32;
	localparam int bus_data_w = 32;
	localparam int reg_w = 16;

	localparam logic [bus_addr_w-1:0] base_addr = 32'h4171_0000;

	// Byte offsets are four times the word index
	localparam logic [bus_addr_w-1:0] sr_offset       = 4 * 32'h00;
	localparam logic [bus_addr_w-1:0] cr_offset       = 4 * 32'h01;
	localparam logic [bus_addr_w-1:0] ver_offset      = 4 * 32'h02;
	localparam logic [bus_addr_w-1:0] bpm_dia_offset  = 4 * 32'h17;
	localparam logic [bus_addr_w-1:0] afe_ctrl_offset = 4 * 32'h58;
	localparam logic [bus_addr_w-1:0] vga_gain_offset = 4 * 32'h6D;

	localparam logic [bus_data_w-1:0] fpga_version = 32'd20170517;

	// Control register bits used by the front end
	localparam int cr_sma_trig_bit  = 3;	// Trigger onto the SMA pin
	localparam int cr_auto_gain_bit = 6;	// Automatic VGA gain
	localparam int cr_pickup_bit    = 13;	// Force the pickup path

	////////////////////////////////////////
	// Front end and attenuator
	////////////////////////////////////////
	localparam int gain_w = 5;
	localparam int att_w = 6;
	localparam int att_half_bit = 1;	// Cycles per att_clk phase
	localparam int att_phase_w = 4;
	localparam int att_bit_w = 3;

	// Loader FSM encodings
	localparam logic [2:0] att_st_idle    = 3'd0;
	localparam logic [2:0] att_st_shift   = 3'd1;
	localparam logic [2:0] att_st_latch   = 3'd2;
	localparam logic [2:0] att_st_ack     = 3'd3;
	localparam logic [2:0] att_st_release = 3'd4;

	// Front-end control word, raw host view or decoded fields
	typedef union packed {
		logic [reg_w-1:0] raw;
		struct packed {
			logic [1:0]        rsvd_hi;
			logic [att_w-1:0]  att;		// Step attenuator setting
			logic [2:0]        rsvd_lo;
			logic [gain_w-1:0] gain;	// Manual VGA gain
		} f;
	} afe_ctrl_word_u;

endpackage

`default_nettype wire

//--- verilog/bpm_host_regs.sv
`timescale 1ns/1ps
`default_nettype none

module bpm_host_regs (
	input  wire                            clk,
	input  wire                            reset,
	input  wire                            bus_en,
	input  wire [3:0]                      bus_we,
	input  wire [bpm_pkg::bus_addr_w-1:0]  bus_addr,
	input  wire [bpm_pkg::bus_data_w-1:0]  bus_wr_data,
	input  wire [bpm_pkg::gain_w-1:0]      vga_gain,
	input  wire                            att_ack,
	output logic [bpm_pkg::bus_data_w-1:0] bus_rd_data,
	output logic [bpm_pkg::reg_w-1:0]      control,
	output bpm_pkg::afe_ctrl_word_u        afe_word,
	output logic                           att_req,
	output logic [bpm_pkg::att_w-1:0]      att_setting
);

	import bpm_pkg::*;

	afe_ctrl_word_u   wr_word;
	logic [reg_w-1:0] bpm_dia;
	logic [reg_w-1:0] status;
	logic             wr_en;
	logic             rd_en;
	logic             afe_wr;
	logic             att_busy;
	logic             pending;
	logic             start;

	assign wr_en = bus_en && (bus_we == 4'hF);	// Partial enables write nothing
	assign rd_en = bus_en && (bus_we == 4'h0);
	assign wr_word.raw = bus_wr_data[reg_w-1:0];
	assign afe_wr = wr_en && (bus_addr == base_addr + afe_ctrl_offset);

	assign att_busy = att_req | att_ack;
	assign status = {{(reg_w-1){1'b0}}, att_busy};

	////////////////////////////////////////
	// Writable registers
	////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (reset) begin
			control <= '0;
			bpm_dia <= '0;
			afe_word <= '0;
		end else if (wr_en) begin
			case (bus_addr)
				base_addr + cr_offset:       control <= bus_wr_data[reg_w-1:0];
				base_addr + bpm_dia_offset:  bpm_dia <= bus_wr_data[reg_w-1:0];
				base_addr + afe_ctrl_offset: afe_word.raw <= wr_word.raw;
				default: ;
			endcase
		end
	end

	////////////////////////////////////////
	// Read mux, one cycle latency
	////////////////////////////////////////
	// Unmapped reads keep the last word
	always_ff @(posedge clk) begin
		if (bus_en) begin
			case (bus_addr)
				base_addr + sr_offset: begin
					// Status answers any enabled access
					bus_rd_data <= {{(bus_data_w-reg_w){1'b0}}, status};
				end
				base_addr + cr_offset: begin
					if (rd_en)
						bus_rd_data <= {{(bus_data_w-reg_w){control[reg_w-1]}}, control};
				end
				base_addr + ver_offset: begin
					if (rd_en)
						bus_rd_data <= fpga_version;
				end
				base_addr + bpm_dia_offset: begin
					if (rd_en)
						bus_rd_data <= {{(bus_data_w-reg_w){1'b0}}, bpm_dia};
				end
				base_addr + afe_ctrl_offset: begin
					if (rd_en) begin
						bus_rd_data <= {{(bus_data_w-reg_w){afe_word.raw[reg_w-1]}},
							afe_word.raw};
					end
				end
				base_addr + vga_gain_offset: begin
					if (rd_en)
						bus_rd_data <= {{(bus_data_w-gain_w){1'b0}}, vga_gain};	// Gain in use
				end
				default: ;
			endcase
		end
	end

	////////////////////////////////////////
	// Attenuator request side
	////////////////////////////////////////
	// New load only from a fully idle handshake
	assign start = (pending | afe_wr) & ~att_req & ~att_ack;

	always_ff @(posedge clk) begin
		if (reset) begin
			att_req <= 1'b0;
			pending <= 1'b0;
		end else begin
			if (start)
				att_req <= 1'b1;
			else if (att_ack)
				att_req <= 1'b0;	// Drop once the loader acknowledges

			if (start)
				pending <= 1'b0;
			else if (afe_wr)
				pending <= 1'b1;	// Writes during a transfer merge here
		end
	end

	// Held for the whole request, newest word wins
	always_ff @(posedge clk) begin
		if (start)
			att_setting <= afe_wr ? wr_word.f.att : afe_word.f.att;
	end

endmodule

`default_nettype wire

//--- verilog/att_serial_writer.sv
`timescale 1ns/1ps
`default_nettype none

module att_serial_writer (
	input  wire                       clk,
	input  wire                       reset,
	input  wire                       att_req,
	input  wire [bpm_pkg::att_w-1:0]  att_setting,
	output logic                      att_ack,
	output logic                      att_clk,
	output logic                      att_data,
	output logic                      att_le
);

	import bpm_pkg::*;

	logic [2:0]             state;
	logic [att_w-1:0]       shreg;		// Remaining bits, MSB next
	logic [att_bit_w-1:0]   bit_cnt;
	logic [att_phase_w-1:0] half_cnt;
	logic                   phase_end;

	assign phase_end = (half_cnt == att_phase_w'(att_half_bit - 1));

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= att_st_idle;
			att_ack <= 1'b0;
			att_clk <= 1'b0;
			att_data <= 1'b0;
			att_le <= 1'b0;
			bit_cnt <= '0;
			half_cnt <= '0;
		end else begin
			case (state)
				att_st_idle: begin
					if (att_req) begin
						shreg <= att_setting;
						att_data <= att_setting[att_w-1];	// First bit set up with clk low
						bit_cnt <= '0;
						half_cnt <= '0;
						state <= att_st_shift;
					end
				end
				att_st_shift: begin
					if (!phase_end) begin
						half_cnt <= half_cnt + 1'b1;
					end else begin
						half_cnt <= '0;
						if (!att_clk) begin
							att_clk <= 1'b1;	// Part samples on this edge
						end else begin
							att_clk <= 1'b0;
							if (bit_cnt == att_bit_w'(att_w - 1)) begin
								att_le <= 1'b1;
								state <= att_st_latch;
							end else begin
								bit_cnt <= bit_cnt + 1'b1;
								att_data <= shreg[att_w-2];
								shreg <= shreg << 1;
							end
						end
					end
				end
				att_st_latch: begin
					if (!phase_end) begin
						half_cnt <= half_cnt + 1'b1;
					end else begin
						half_cnt <= '0;
						att_le <= 1'b0;
						att_data <= 1'b0;
						att_ack <= 1'b1;
						state <= att_st_ack;
					end
				end
				att_st_ack: begin
					if (!att_req) begin	// Host has seen the ack
						att_ack <= 1'b0;
						state <= att_st_release;
					end
				end
				att_st_release: state <= att_st_idle;	// One idle cycle with ack low
				default: state <= att_st_idle;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- verilog/afe_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module afe_ctrl (
	input  wire                            clk,
	input  wire                            reset,
	input  wire [bpm_pkg::reg_w-1:0]       control,
	input  wire bpm_pkg::afe_ctrl_word_u   afe_word,
	input  wire [bpm_pkg::gain_w-1:0]      auto_gain,
	input  wire                            trig_in,
	input  wire                            cal_on,
	input  wire                            att_req,
	input  wire [bpm_pkg::att_w-1:0]       att_setting,
	output wire                            att_ack,
	output wire                            att_clk,
	output wire                            att_data,
	output wire                            att_le,
	output logic                           afe_pickup,
	output logic                           afe_cal,
	output logic                           sma_out,
	output logic [bpm_pkg::gain_w-1:0]     vga_gain
);

	import bpm_pkg::*;

	// Gain source select
	assign vga_gain = control[cr_auto_gain_bit] ? auto_gain : afe_word.f.gain;

	// Calibration path unless pickup is forced
	assign afe_pickup = control[cr_pickup_bit] ? 1'b1 : cal_on;
	assign afe_cal = ~afe_pickup;

	// Board has an inverting gate after this pin
	assign sma_out = control[cr_sma_trig_bit] ? ~trig_in : 1'b1;

	att_serial_writer att0 (
		.clk         (clk),
		.reset       (reset),
		.att_req     (att_req),
		.att_setting (att_setting),
		.att_ack     (att_ack),
		.att_clk     (att_clk),
		.att_data    (att_data),
		.att_le      (att_le)
	);

endmodule

`default_nettype wire

//--- verilog/bpm_top.sv
`timescale 1ns/1ps
`default_nettype none

module bpm_top (
	input  wire                            clk,
	input  wire                            reset,
	input  wire                            bus_en,
	input  wire [3:0]                      bus_we,
	input  wire [bpm_pkg::bus_addr_w-1:0]  bus_addr,
	input  wire [bpm_pkg::bus_data_w-1:0]  bus_wr_data,
	output wire [bpm_pkg::bus_data_w-1:0]  bus_rd_data,
	input  wire                            trig_in,
	input  wire                            cal_on,
	input  wire [bpm_pkg::gain_w-1:0]      auto_gain,
	output wire                            att_clk,
	output wire                            att_data,
	output wire                            att_le,
	output wire                            afe_pickup,
	output wire                            afe_cal,
	output wire                            sma_out,
	output wire [bpm_pkg::gain_w-1:0]      vga_gain
);

	import bpm_pkg::*;

	wire [reg_w-1:0]     control;
	wire afe_ctrl_word_u afe_word;
	wire                 att_req;	// Four-phase load handshake
	wire                 att_ack;
	wire [att_w-1:0]     att_setting;

	bpm_host_regs regs0 (
		.clk         (clk),
		.reset       (reset),
		.bus_en      (bus_en),
		.bus_we      (bus_we),
		.bus_addr    (bus_addr),
		.bus_wr_data (bus_wr_data),
		.vga_gain    (vga_gain),	// Read back as actual gain
		.att_ack     (att_ack),
		.bus_rd_data (bus_rd_data),
		.control     (control),
		.afe_word    (afe_word),
		.att_req     (att_req),
		.att_setting (att_setting)
	);

	afe_ctrl afe0 (
		.clk         (clk),
		.reset       (reset),
		.control     (control),
		.afe_word    (afe_word),
		.auto_gain   (auto_gain),
		.trig_in     (trig_in),
		.cal_on      (cal_on),
		.att_req     (att_req),
		.att_setting (att_setting),
		.att_ack     (att_ack),
		.att_clk     (att_clk),
		.att_data    (att_data),
		.att_le      (att_le),
		.afe_pickup  (afe_pickup),
		.afe_cal     (afe_cal),
		.sma_out     (sma_out),
		.vga_gain    (vga_gain)
	);

endmodule

`default_nettype wire

//--- testbench/bpm_tb_assert.sv
`timescale 1ns/1ps
`default_nettype none

module bpm_tb_assert (
	input wire                       clk,
	input wire                       reset,
	input wire                       att_req,
	input wire [bpm_pkg::att_w-1:0]  att_setting,
	input wire                       att_ack,
	input wire                       att_clk,
	input wire                       att_le
);

	int fail_cnt = 0;	// Read by the testbench

	////////////////////////////////////////
	// Four-phase handshake order
	////////////////////////////////////////
	req_from_idle: assert property (@(posedge clk) disable iff (reset)
		$rose(att_req) |-> !att_ack) else begin
		fail_cnt++;
		$error("att_req rose while att_ack was still high");
	end

	ack_on_req: assert property (@(posedge clk) disable iff (reset)
		$rose(att_ack) |-> att_req) else begin
		fail_cnt++;
		$error("att_ack rose without a pending att_req");
	end

	req_drop_after_ack: assert property (@(posedge clk) disable iff (reset)
		$fell(att_req) |-> att_ack) else begin
		fail_cnt++;
		$error("att_req fell before att_ack was seen");
	end

	ack_drop_after_req: assert property (@(posedge clk) disable iff (reset)
		$fell(att_ack) |-> !att_req) else begin
		fail_cnt++;
		$error("att_ack fell while att_req was high");
	end

	// Setting held for the whole request
	setting_stable: assert property (@(posedge clk) disable iff (reset)
		att_req && $past(att_req) |-> $stable(att_setting)) else begin
		fail_cnt++;
		$error("att_setting changed while att_req was high");
	end

	////////////////////////////////////////
	// Serial stream timing
	////////////////////////////////////////
	// One cycle to accept, 13 to shift and latch, then ack
	transfer_length: assert property (@(posedge clk) disable iff (reset)
		$rose(att_req) |-> ##14 $rose(att_ack)) else begin
		fail_cnt++;
		$error("att_ack did not rise 14 cycles after att_req");
	end

	le_then_ack: assert property (@(posedge clk) disable iff (reset)
		$rose(att_le) |=> !att_le && att_ack) else begin
		fail_cnt++;
		$error("latch pulse was not one cycle followed by att_ack");
	end

	le_clk_apart: assert property (@(posedge clk) disable iff (reset)
		!(att_le && att_clk)) else begin
		fail_cnt++;
		$error("att_le and att_clk were high together");
	end

endmodule

`default_nettype wire

//--- testbench/bpm_tb.sv
`timescale 1ns/1ps
`default_nettype none

module bpm_tb;

	import bpm_pkg::*;

	localparam int timeout_cycles = 3000;	// Whole run needs a few hundred

	logic                  clk;
	logic                  reset;
	logic                  bus_en;
	logic [3:0]            bus_we;
	logic [bus_addr_w-1:0] bus_addr;
	logic [bus_data_w-1:0] bus_wr_data;
	wire  [bus_data_w-1:0] bus_rd_data;
	logic                  trig_in;
	logic                  cal_on;
	logic [gain_w-1:0]     auto_gain;
	wire                   att_clk;
	wire                   att_data;
	wire                   att_le;
	wire                   afe_pickup;
	wire                   afe_cal;
	wire                   sma_out;
	wire  [gain_w-1:0]     vga_gain;

	int               cycle_cnt = 0;
	logic [15:0]      afe_shadow = '0;	// Last word written to the AFE control
	logic [att_w-1:0] shifted = '0;
	logic [att_w-1:0] latched[$];		// One entry per att_le pulse

	bpm_top dut0 (.*);

	bind att_serial_writer bpm_tb_assert chk0 (.clk(clk), .reset(reset), .att_req(att_req),
		.att_setting(att_setting), .att_ack(att_ack), .att_clk(att_clk), .att_le(att_le));

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// Model of the attenuator part shifting in MSB first
	always @(posedge att_clk) shifted = {shifted[att_w-2:0], att_data};
	always @(posedge att_le) latched.push_back(shifted);

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("Test failures found");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got === exp)
		else fail_run($sformatf("mismatch %s: got 0x%08h, expected 0x%08h", name, got, exp));
	endtask

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt == timeout_cycles)
			fail_run("Timeout, the run did not finish within the cycle limit");
		else if (dut0.afe0.att0.chk0.fail_cnt != 0)
			fail_run("An assertion on the attenuator loader failed");
	end

	////////////////////////////////////////
	// Bus access
	////////////////////////////////////////
	task automatic bus_write(input logic [31:0] offset, input logic [31:0] data,
		input logic [3:0] we);
		@(posedge clk);
		bus_en <= 1'b1;
		bus_we <= we;
		bus_addr <= base_addr + offset;
		bus_wr_data <= data;
		@(posedge clk);
		bus_en <= 1'b0;
		bus_we <= 4'h0;
	endtask

	task automatic bus_read(input logic [31:0] offset, output logic [31:0] data);
		@(posedge clk);
		bus_en <= 1'b1;
		bus_we <= 4'h0;
		bus_addr <= base_addr + offset;
		@(posedge clk);
		bus_en <= 1'b0;
		@(negedge clk);
		data = bus_rd_data;	// Registered on the edge after the request
	endtask

	task automatic write_afe(input logic [15:0] word);
		bus_write(afe_ctrl_offset, {16'h0, word}, 4'hF);
		afe_shadow = word;
	endtask

	task automatic wait_latches(input int count);
		while (latched.size() < count)
			@(posedge clk);
	endtask

	task automatic wait_loader_idle;
		logic [31:0] sr;
		sr = 32'h1;
		while (sr[0])
			bus_read(sr_offset, sr);
	endtask

	// Random front-end inputs against the routing rules
	task automatic check_routing(input logic [15:0] ctrl);
		logic [gain_w-1:0] exp_gain;
		logic              exp_pick;
		logic              exp_sma;
		bus_write(cr_offset, {16'h0, ctrl}, 4'hF);
		repeat (8) begin
			@(posedge clk);
			auto_gain <= 5'($urandom);
			cal_on <= 1'($urandom);
			trig_in <= 1'($urandom);
			@(negedge clk);
			exp_gain = ctrl[6] ? auto_gain : afe_shadow[4:0];
			exp_pick = ctrl[13] ? 1'b1 : cal_on;
			exp_sma = ctrl[3] ? !trig_in : 1'b1;
			check_value("vga_gain", 32'(vga_gain), 32'(exp_gain));
			check_value("afe_pickup", 32'(afe_pickup), 32'(exp_pick));
			check_value("afe_cal", 32'(afe_cal), 32'(!exp_pick));
			check_value("sma_out", 32'(sma_out), 32'(exp_sma));
		end
	endtask

	////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////
	initial begin
		logic [15:0] val_a;
		logic [15:0] val_b;
		logic [31:0] rd;
		int          base;
		void'($urandom(34624));
		reset = 1'b1;
		bus_en = 1'b0;
		bus_we = 4'h0;
		bus_addr = '0;
		bus_wr_data = '0;
		trig_in = 1'b0;
		cal_on = 1'b0;
		auto_gain = '0;
		repeat (8) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		check_value("att_clk", 32'(att_clk), 32'h0);
		check_value("att_le", 32'(att_le), 32'h0);
		check_value("att_data", 32'(att_data), 32'h0);
		check_value("sma_out", 32'(sma_out), 32'h1);

		bus_read(ver_offset, rd);
		check_value("version", rd, fpga_version);
		val_a = 16'($urandom);
		bus_write(bpm_dia_offset, {16'h0, val_a}, 4'hF);
		bus_write(bpm_dia_offset, ~{16'h0, val_a}, 4'h3);	// Partial byte enables write nothing
		bus_read(bpm_dia_offset, rd);
		check_value("bpm_dia", rd, {16'h0, val_a});
		val_b = 16'($urandom) | 16'h8000;
		bus_write(cr_offset, {16'h0, val_b}, 4'hF);
		bus_read(cr_offset, rd);
		check_value("control", rd, {{16{val_b[15]}}, val_b});

		// Single attenuator load
		val_a = 16'($urandom);
		base = latched.size();
		write_afe(val_a);
		bus_read(sr_offset, rd);
		check_value("status", rd, 32'h1);
		wait_latches(base + 1);
		wait_loader_idle();
		bus_read(sr_offset, rd);
		check_value("status", rd, 32'h0);
		check_value("att_bits", 32'(latched[base]), 32'(val_a[13:8]));
		bus_read(afe_ctrl_offset, rd);
		check_value("afe_ctrl", rd, {{16{val_a[15]}}, val_a});

		// Second write lands while the first load runs
		val_a = 16'($urandom);
		val_b = 16'($urandom);
		base = latched.size();
		write_afe(val_a);
		write_afe(val_b);
		wait_latches(base + 2);
		wait_loader_idle();
		repeat (20) @(posedge clk);
		check_value("latch_count", 32'(latched.size() - base), 32'h2);
		check_value("att_bits", 32'(latched[base]), 32'(val_a[13:8]));
		check_value("att_bits", 32'(latched[base + 1]), 32'(val_b[13:8]));

		check_routing(16'h0000);
		bus_read(vga_gain_offset, rd);
		check_value("vga_gain_reg", rd, {27'h0, afe_shadow[4:0]});
		check_routing(16'h0040);
		check_routing(16'h2000);
		check_routing(16'h0008);
		check_routing(16'($urandom));

		repeat (4) @(posedge clk);
		if (dut0.afe0.att0.chk0.fail_cnt != 0) begin
			fail_run("An assertion on the attenuator loader failed");
		end else begin
			$display("All tests passed!");
			$finish;
		end
	end

endmodule

`default_nettype wire

//--- vlog.f
verilog/bpm_pkg.sv
verilog/bpm_host_regs.sv
verilog/att_serial_writer.sv
verilog/afe_ctrl.sv
verilog/bpm_top.sv
testbench/bpm_tb_assert.sv
testbench/bpm_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the BPM control core simulation with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/1ps --top-module bpm_tb -f vlog.f

# Keep running past assertion errors so the testbench reports them
./obj_dir/Vbpm_tb +verilator+error+limit+100 2>&1 | tee sim.log

grep -q "All tests passed!" sim.log
